// File: logic/soc_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared definitions for the load/store side of the SoC fabric
// bus widths, vector types, address map and GPIO register layout
// imported by wildcard into every module header that needs them
////////////////////////////////////////////////////////////////////////////

package soc_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // load/store bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned lsb_daw = 15;  // byte address width
  localparam int unsigned lsb_ddw = 32;  // data width
  localparam int unsigned lsb_dbw = 4;   // byte enable width

  typedef logic [lsb_daw-1:0] lsb_adr_t;  // byte address
  typedef logic [lsb_ddw-1:0] lsb_dat_t;  // write/read data
  typedef logic [lsb_dbw-1:0] lsb_ben_t;  // byte enables

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  // lower half is data memory, upper half is peripherals
  localparam int unsigned periph_bit = 14;
  // inside the peripheral half: 0 GPIO, 1 empty UART slot
  localparam int unsigned slot_bit = 6;

  // request target, registered for the response cycle
  typedef enum logic [1:0] {
    TGT_MEM,   // data memory
    TGT_GPIO,  // GPIO controller
    TGT_ERR    // no device, error response
  } tgt_e;

  ////////////////////////////////////////////////////////////////////////////
  // GPIO register layout
  ////////////////////////////////////////////////////////////////////////////

  // word offsets from address bits 3:2
  localparam logic [1:0] gpio_ofs_out = 2'd0;  // output value
  localparam logic [1:0] gpio_ofs_ena = 2'd1;  // output enable
  localparam logic [1:0] gpio_ofs_in  = 2'd2;  // synchronized input, read only
  // offset 3 is unused and reads as zero

  // input synchronizer depth
  localparam int unsigned gpio_sync_stages = 2;

endpackage : soc_bus_pkg

// File: logic/lsb_decoder.sv
////////////////////////////////////////////////////////////////////////////
// load/store bus decoder
// splits each request between memory, GPIO and the error slot, then
// muxes the registered response of the selected target one cycle later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsb_decoder
  import soc_bus_pkg::*;
(
  // system
  input  logic     clk,
  input  logic     rst,
  // request side
  input  logic     lsb_vld,   // request strobe
  input  lsb_adr_t lsb_adr,   // byte address
  // target strobes
  output logic     mem_vld,   // data memory request
  output logic     gpio_vld,  // GPIO request
  // target read data
  input  lsb_dat_t mem_rdt,
  input  lsb_dat_t gpio_rdt,
  // response side
  output lsb_dat_t lsb_rdt,   // read data
  output logic     lsb_err    // error flag
);

  ////////////////////////////////////////////////////////////////////////////
  // request phase
  ////////////////////////////////////////////////////////////////////////////

  tgt_e req_tgt;  // target of the current address
  tgt_e rsp_tgt;  // target of the request one cycle back
  logic rsp_vld;  // a request was taken last cycle

  // address classification
  always_comb begin
    if (!lsb_adr[periph_bit]) begin
      req_tgt = TGT_MEM;        // lower half
    end else if (!lsb_adr[slot_bit]) begin
      req_tgt = TGT_GPIO;       // peripheral slot 0
    end else begin
      req_tgt = TGT_ERR;        // empty UART slot
    end
  end

  // strobes straight from the request, no wait states
  assign mem_vld  = lsb_vld & (req_tgt == TGT_MEM);
  assign gpio_vld = lsb_vld & (req_tgt == TGT_GPIO);

  ////////////////////////////////////////////////////////////////////////////
  // response phase
  ////////////////////////////////////////////////////////////////////////////

  // target held between requests, so idle cycles keep the last select
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_tgt <= TGT_MEM;
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= lsb_vld;
      if (lsb_vld) begin
        rsp_tgt <= req_tgt;
      end
    end
  end

  // response mux
  always_comb begin
    case (rsp_tgt)
      TGT_MEM:  lsb_rdt = mem_rdt;
      TGT_GPIO: lsb_rdt = gpio_rdt;
      default:  lsb_rdt = '0;      // error slot drives zero
    endcase
  end

  // error only for a request that actually hit the empty slot
  assign lsb_err = rsp_vld & (rsp_tgt == TGT_ERR);

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // one target per request, strobe matches the address half
  a_one_hot_vld : assert property (
    @(posedge clk) disable iff (rst)
    (mem_vld || gpio_vld) |-> (mem_vld != gpio_vld) && (gpio_vld == lsb_adr[periph_bit])
  ) else $error("decoder: strobes high together or off the address map");

  // error is a response to a request into the empty slot the cycle before
  a_err_after_req : assert property (
    @(posedge clk) disable iff (rst)
    lsb_err |-> $past(lsb_vld && lsb_adr[periph_bit] && lsb_adr[slot_bit])
  ) else $error("decoder: lsb_err without a preceding request to the empty slot");

endmodule : lsb_decoder

// File: logic/data_mem.sv
////////////////////////////////////////////////////////////////////////////
// on-chip data memory, single port with byte enables
// read data registered, available one cycle after the request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module data_mem
  import soc_bus_pkg::*;
#(
  parameter int unsigned MEM_AW = 12  // word address width
)(
  input  logic     clk,
  input  logic     rst,  // clears the read register only
  input  logic     vld,  // request strobe from the decoder
  input  logic     wen,  // write enable
  input  lsb_adr_t adr,  // byte address
  input  lsb_ben_t ben,  // byte enables
  input  lsb_dat_t wdt,  // write data
  output lsb_dat_t rdt   // read data
);

  localparam int unsigned ofs_w = $clog2(lsb_dbw);  // byte offset bits

  // memory must fit in the lower half of the map
  if (MEM_AW + ofs_w > periph_bit) begin : gen_size_check
    $error("data_mem: MEM_AW too large for the memory half");
  end

  lsb_dat_t          mem [0:2**MEM_AW-1];  // storage, no reset
  logic [MEM_AW-1:0] wrd;                  // word index

  // upper address bits ignored, memory repeats across the half
  assign wrd = adr[MEM_AW+ofs_w-1:ofs_w];

  // byte lane write
  always_ff @(posedge clk) begin
    if (vld && wen) begin
      for (int b = 0; b < lsb_dbw; b++) begin
        if (ben[b]) begin
          mem[wrd][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  // registered read, held until the next read
  always_ff @(posedge clk) begin
    if (rst) begin
      rdt <= '0;
    end else if (vld && !wen) begin
      rdt <= mem[wrd];
    end
  end

  // unknown address would index an undefined word
  a_adr_known : assert property (
    @(posedge clk) disable iff (rst)
    vld |-> !$isunknown(adr)
  ) else $error("data_mem: unknown address on request");

endmodule : data_mem

// File: logic/gpio_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// GPIO controller on the load/store bus
// output and enable registers with byte lane writes, synchronized input,
// register read-back one cycle after the request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_ctrl
  import soc_bus_pkg::*;
#(
  parameter int unsigned GW = 32  // GPIO width
)(
  // system
  input  logic          clk,
  input  logic          rst,
  // bus side
  input  logic          vld,     // request strobe from the decoder
  input  logic          wen,     // write enable
  input  lsb_adr_t      adr,     // byte address, only 3:2 decoded
  input  lsb_ben_t      ben,     // byte enables
  input  lsb_dat_t      wdt,     // write data
  output lsb_dat_t      rdt,     // read data
  // pins
  input  logic [GW-1:0] gpio_i,  // input, asynchronous
  output logic [GW-1:0] gpio_o,  // output value
  output logic [GW-1:0] gpio_e   // output enable
);

  // registers must fit in one bus word
  if (GW > lsb_ddw) begin : gen_width_check
    $error("gpio_ctrl: GW wider than the data bus");
  end

  ////////////////////////////////////////////////////////////////////////////
  // register access decode
  ////////////////////////////////////////////////////////////////////////////

  logic [1:0]    ofs;      // word offset
  logic          out_wr;   // write to output register
  logic          ena_wr;   // write to enable register
  logic [GW-1:0] lane_msk; // byte enables spread to bits

  assign ofs    = adr[3:2];
  assign out_wr = vld & wen & (ofs == gpio_ofs_out);
  assign ena_wr = vld & wen & (ofs == gpio_ofs_ena);

  always_comb begin
    for (int i = 0; i < GW; i++) begin
      lane_msk[i] = ben[i/8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output and enable registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_o <= '0;
      gpio_e <= '0;  // all pins start as inputs
    end else begin
      if (out_wr) gpio_o <= (gpio_o & ~lane_msk) | (wdt[GW-1:0] & lane_msk);
      if (ena_wr) gpio_e <= (gpio_e & ~lane_msk) | (wdt[GW-1:0] & lane_msk);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_sync_stages-1:0][GW-1:0] sync_q;  // stage 0 samples the pins

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[gpio_sync_stages-2:0], gpio_i};  // shift toward the top
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////////////////////

  // writes to the input offset simply fall through here
  always_ff @(posedge clk) begin
    if (rst) begin
      rdt <= '0;
    end else if (vld && !wen) begin
      case (ofs)
        gpio_ofs_out: rdt <= lsb_dat_t'(gpio_o);
        gpio_ofs_ena: rdt <= lsb_dat_t'(gpio_e);
        gpio_ofs_in:  rdt <= lsb_dat_t'(sync_q[gpio_sync_stages-1]);
        default:      rdt <= '0;  // unused offset
      endcase
    end
  end

  // pins never float to X once out of reset
  a_pins_known : assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({gpio_o, gpio_e})
  ) else $error("gpio_ctrl: unknown value on gpio_o or gpio_e");

endmodule : gpio_ctrl

// File: logic/soc_fabric.sv
////////////////////////////////////////////////////////////////////////////
// load/store fabric top level
// the core's data bus is brought out to ports, feeding the decoder,
// the data memory and the GPIO controller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_fabric
  import soc_bus_pkg::*;
#(
  parameter int unsigned GW     = 32,  // GPIO width
  parameter int unsigned MEM_AW = 12   // data memory word address width
)(
  // system
  input  logic          clk,
  input  logic          rst,
  // load/store bus, driven by the core side
  input  logic          lsb_vld,  // request strobe
  input  logic          lsb_wen,  // write enable
  input  lsb_adr_t      lsb_adr,  // byte address
  input  lsb_ben_t      lsb_ben,  // byte enables
  input  lsb_dat_t      lsb_wdt,  // write data
  output lsb_dat_t      lsb_rdt,  // read data, next cycle
  output logic          lsb_err,  // error flag, next cycle
  // GPIO pins
  input  logic [GW-1:0] gpio_i,
  output logic [GW-1:0] gpio_o,
  output logic [GW-1:0] gpio_e
);

  // decoder to target strobes and target read data
  logic     mem_vld;
  logic     gpio_vld;
  lsb_dat_t mem_rdt;
  lsb_dat_t gpio_rdt;

  ////////////////////////////////////////////////////////////////////////////
  // address decoder and response mux
  ////////////////////////////////////////////////////////////////////////////

  lsb_decoder u_dec (
    .clk      (clk),
    .rst      (rst),
    .lsb_vld  (lsb_vld),
    .lsb_adr  (lsb_adr),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt),
    .lsb_rdt  (lsb_rdt),
    .lsb_err  (lsb_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // targets, wen/adr/ben/wdt shared by both
  ////////////////////////////////////////////////////////////////////////////

  data_mem #(
    .MEM_AW (MEM_AW)
  ) u_mem (
    .clk (clk),
    .rst (rst),
    .vld (mem_vld),
    .wen (lsb_wen),
    .adr (lsb_adr),
    .ben (lsb_ben),
    .wdt (lsb_wdt),
    .rdt (mem_rdt)
  );

  gpio_ctrl #(
    .GW (GW)
  ) u_gpio (
    .clk    (clk),
    .rst    (rst),
    .vld    (gpio_vld),
    .wen    (lsb_wen),
    .adr    (lsb_adr),
    .ben    (lsb_ben),
    .wdt    (lsb_wdt),
    .rdt    (gpio_rdt),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e)
  );

endmodule : soc_fabric

// File: verification/soc_fabric_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the load/store fabric
// plays the core on the data bus, checks memory, GPIO and the error slot
// against a byte-lane memory model and the bus response rules
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_fabric_tb
  import soc_bus_pkg::*;
;

  localparam int unsigned GW        = 32;
  localparam int unsigned MEM_AW    = 12;
  localparam int unsigned mem_words = 2**MEM_AW;
  localparam int unsigned n_fill    = 32;  // full-word writes
  localparam int unsigned n_part    = 32;  // partial writes over filled words
  localparam int unsigned n_burst   = 16;  // back-to-back reads
  // single accesses over all tests, two cycles each
  localparam int unsigned n_access  = 2 + 2*n_fill + n_part + 2 + 14 + 8;
  localparam int unsigned run_cycles = 5 + 2*n_access + n_burst + 2 + gpio_sync_stages + 2;
  localparam int unsigned wd_cycles  = run_cycles + 200;  // margin

  logic          clk;
  logic          rst;
  logic          lsb_vld;
  logic          lsb_wen;
  lsb_adr_t      lsb_adr;
  lsb_ben_t      lsb_ben;
  lsb_dat_t      lsb_wdt;
  lsb_dat_t      lsb_rdt;
  logic          lsb_err;
  logic [GW-1:0] gpio_i;
  logic [GW-1:0] gpio_o;
  logic [GW-1:0] gpio_e;

  int            seed = 68498;
  lsb_dat_t      mem_model [mem_words];  // mirror of written words
  int unsigned   used_idx [$];           // word indices holding known data
  lsb_dat_t      gpio_out_exp;           // expected GPIO registers
  lsb_dat_t      gpio_ena_exp;

  soc_fabric #(
    .GW     (GW),
    .MEM_AW (MEM_AW)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .lsb_vld (lsb_vld),
    .lsb_wen (lsb_wen),
    .lsb_adr (lsb_adr),
    .lsb_ben (lsb_ben),
    .lsb_wdt (lsb_wdt),
    .lsb_rdt (lsb_rdt),
    .lsb_err (lsb_err),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", wd_cycles);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_dat(input string name, input lsb_dat_t exp, input lsb_dat_t act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "data mismatch on %s", name);
    end
  endtask

  task automatic check_gpio(input string name, input logic [GW-1:0] exp,
                            input logic [GW-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "pin mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // address helpers and byte lane rule
  ////////////////////////////////////////////////////////////////////////////

  function automatic lsb_adr_t mem_addr(input int unsigned idx);
    return lsb_adr_t'(idx << 2);  // memory half, byte offset 0
  endfunction

  function automatic lsb_adr_t gpio_addr(input logic [1:0] ofs);
    lsb_adr_t a;
    a = '0;
    a[periph_bit] = 1'b1;  // peripheral half, slot 0
    a[3:2] = ofs;
    return a;
  endfunction

  // enabled bytes take the new value, others keep the old one
  function automatic lsb_dat_t lane_merge(input lsb_dat_t old_v, input lsb_dat_t new_v,
                                          input lsb_ben_t ben);
    lsb_dat_t r;
    r = old_v;
    for (int b = 0; b < lsb_dbw; b++) begin
      if (ben[b]) r[8*b +: 8] = new_v[8*b +: 8];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks, response sampled mid-cycle after the capture edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_write(input lsb_adr_t adr, input lsb_ben_t ben, input lsb_dat_t wdt,
                           output logic err);
    @(posedge clk);
    lsb_vld <= 1'b1;
    lsb_wen <= 1'b1;
    lsb_adr <= adr;
    lsb_ben <= ben;
    lsb_wdt <= wdt;
    @(posedge clk);  // request taken here
    lsb_vld <= 1'b0;
    lsb_wen <= 1'b0;
    @(negedge clk);
    err = lsb_err;
  endtask

  task automatic bus_read(input lsb_adr_t adr, output lsb_dat_t rdt, output logic err);
    @(posedge clk);
    lsb_vld <= 1'b1;
    lsb_wen <= 1'b0;
    lsb_adr <= adr;
    lsb_ben <= '0;
    @(posedge clk);
    lsb_vld <= 1'b0;
    @(negedge clk);
    rdt = lsb_rdt;
    err = lsb_err;
  endtask

  // write plus model update
  task automatic write_mem_word(input int unsigned idx, input lsb_ben_t ben,
                                input lsb_dat_t wdt);
    logic err;
    bus_write(mem_addr(idx), ben, wdt, err);
    check_bit("lsb_err", 1'b0, err);
    mem_model[idx] = lane_merge(mem_model[idx], wdt, ben);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    lsb_dat_t rdt;
    logic     err;
    check_gpio("gpio_o", '0, gpio_o);
    check_gpio("gpio_e", '0, gpio_e);
    check_bit("lsb_err", 1'b0, lsb_err);
    check_dat("lsb_rdt", '0, lsb_rdt);
    bus_read(gpio_addr(gpio_ofs_out), rdt, err);
    check_dat("lsb_rdt", '0, rdt);
    check_bit("lsb_err", 1'b0, err);
    bus_read(gpio_addr(gpio_ofs_ena), rdt, err);
    check_dat("lsb_rdt", '0, rdt);
    check_bit("lsb_err", 1'b0, err);
  endtask

  task automatic test_memory();
    int unsigned idx;
    lsb_adr_t    adr;
    lsb_dat_t    rdt;
    logic        err;
    for (int i = 0; i < n_fill; i++) begin  // full words first, no X bytes later
      idx = {$random(seed)} % mem_words;
      used_idx.push_back(idx);
      write_mem_word(idx, 4'hf, $random(seed));
    end
    for (int i = 0; i < n_part; i++) begin
      idx = used_idx[{$random(seed)} % used_idx.size()];
      write_mem_word(idx, lsb_ben_t'($random(seed)), $random(seed));
    end
    foreach (used_idx[i]) begin
      bus_read(mem_addr(used_idx[i]), rdt, err);
      check_dat("lsb_rdt", mem_model[used_idx[i]], rdt);
      check_bit("lsb_err", 1'b0, err);
    end
    // alias of the same word, byte offset and bits above the array set
    idx = used_idx[0];
    adr = mem_addr(idx) | lsb_adr_t'(3);
    for (int b = MEM_AW + 2; b < periph_bit; b++) adr[b] = 1'b1;
    bus_read(adr, rdt, err);
    check_dat("lsb_rdt", mem_model[idx], rdt);
    check_bit("lsb_err", 1'b0, err);
  endtask

  task automatic test_burst();
    int unsigned idx_q [$];
    int unsigned k;
    for (int i = 0; i <= n_burst; i++) begin
      @(posedge clk);
      if (i < n_burst) begin
        k = used_idx[{$random(seed)} % used_idx.size()];
        idx_q.push_back(k);
        lsb_vld <= 1'b1;
        lsb_wen <= 1'b0;
        lsb_adr <= mem_addr(k);
        lsb_ben <= '0;
      end else begin
        lsb_vld <= 1'b0;  // last response still pending
      end
      if (i > 0) begin
        @(negedge clk);  // response of the previous request
        check_dat("lsb_rdt", mem_model[idx_q[i-1]], lsb_rdt);
        check_bit("lsb_err", 1'b0, lsb_err);
      end
    end
  endtask

  task automatic test_gpio();
    lsb_dat_t rdt;
    lsb_dat_t pins;
    logic     err;
    gpio_out_exp = 32'hA5C3_0F96;
    bus_write(gpio_addr(gpio_ofs_out), 4'hf, gpio_out_exp, err);
    check_bit("lsb_err", 1'b0, err);
    check_gpio("gpio_o", gpio_out_exp[GW-1:0], gpio_o);
    gpio_out_exp = lane_merge(gpio_out_exp, 32'h1234_5678, 4'b0101);
    bus_write(gpio_addr(gpio_ofs_out), 4'b0101, 32'h1234_5678, err);
    check_gpio("gpio_o", gpio_out_exp[GW-1:0], gpio_o);
    bus_read(gpio_addr(gpio_ofs_out), rdt, err);
    check_dat("lsb_rdt", gpio_out_exp, rdt);
    gpio_ena_exp = 32'h0000_FFFF;
    bus_write(gpio_addr(gpio_ofs_ena), 4'hf, gpio_ena_exp, err);
    check_gpio("gpio_e", gpio_ena_exp[GW-1:0], gpio_e);
    gpio_ena_exp = lane_merge(gpio_ena_exp, 32'hFF00_0000, 4'b1000);  // top lane only
    bus_write(gpio_addr(gpio_ofs_ena), 4'b1000, 32'hFF00_0000, err);
    check_gpio("gpio_e", gpio_ena_exp[GW-1:0], gpio_e);
    bus_read(gpio_addr(gpio_ofs_ena), rdt, err);
    check_dat("lsb_rdt", gpio_ena_exp, rdt);
    bus_write(gpio_addr(gpio_ofs_in), 4'hf, 32'hFFFF_FFFF, err);  // read-only offset
    check_gpio("gpio_o", gpio_out_exp[GW-1:0], gpio_o);
    check_gpio("gpio_e", gpio_ena_exp[GW-1:0], gpio_e);
    pins = $random(seed);
    @(posedge clk);
    gpio_i <= pins[GW-1:0];
    repeat (gpio_sync_stages + 1) @(posedge clk);  // through the synchronizer
    bus_read(gpio_addr(gpio_ofs_in), rdt, err);
    check_dat("lsb_rdt", pins, rdt);
    bus_read(gpio_addr(2'd3), rdt, err);  // unused offset
    check_dat("lsb_rdt", '0, rdt);
    check_bit("lsb_err", 1'b0, err);
  endtask

  task automatic test_uart();
    int unsigned idx;
    lsb_adr_t    adr;
    lsb_dat_t    rdt;
    logic        err;
    idx = used_idx[0];
    adr = mem_addr(idx);  // low bits alias a live memory word
    adr[periph_bit] = 1'b1;
    adr[slot_bit]   = 1'b1;
    bus_read(adr, rdt, err);
    check_bit("lsb_err", 1'b1, err);
    check_dat("lsb_rdt", '0, rdt);
    bus_write(adr, 4'hf, ~mem_model[idx], err);
    check_bit("lsb_err", 1'b1, err);
    bus_read(mem_addr(idx), rdt, err);  // error cleared on the next request
    check_bit("lsb_err", 1'b0, err);
    check_dat("lsb_rdt", mem_model[idx], rdt);
    bus_read(gpio_addr(gpio_ofs_out), rdt, err);
    check_dat("lsb_rdt", gpio_out_exp, rdt);
    bus_read(gpio_addr(gpio_ofs_ena), rdt, err);
    check_dat("lsb_rdt", gpio_ena_exp, rdt);
    check_gpio("gpio_o", gpio_out_exp[GW-1:0], gpio_o);
    check_gpio("gpio_e", gpio_ena_exp[GW-1:0], gpio_e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst     = 1'b1;
    lsb_vld = 1'b0;
    lsb_wen = 1'b0;
    lsb_adr = '0;
    lsb_ben = '0;
    lsb_wdt = '0;
    gpio_i  = '0;
    repeat (4) @(posedge clk);  // 4 cycles of reset
    rst <= 1'b0;
    @(negedge clk);
    test_reset();
    test_memory();
    test_burst();
    test_gpio();
    test_uart();
    $display("Result: PASSED");
    $finish;
  end

endmodule : soc_fabric_tb

// File: sources.f
logic/soc_bus_pkg.sv
logic/lsb_decoder.sv
logic/data_mem.sv
logic/gpio_ctrl.sv
logic/soc_fabric.sv
verification/soc_fabric_tb.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  # package first, then leaf modules, then the top level
  - logic/soc_bus_pkg.sv
  - logic/lsb_decoder.sv
  - logic/data_mem.sv
  - logic/gpio_ctrl.sv
  - logic/soc_fabric.sv

  - target: test
    files:
      - verification/soc_fabric_tb.sv
